// ==== verilog.f ====
+incdir+design
design/ttc_reg_pkg.sv
design/ttc_count_pkg.sv
design/ttc_reg_decode.sv
design/ttc_count_rst_lite.sv
design/ttc_count_exec.sv
design/ttc_irq_result.sv
design/ttc_timer.sv
test/ttc_timer_assertions.sv
test/ttc_timer_tb.sv

// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing --assert --timescale 1ns/1ps
TOP      := ttc_timer_tb
FILELIST := verilog.f
OBJDIR   := obj_dir

SOURCES  := $(wildcard design/*.sv design/*.svh test/*.sv)
BIN      := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: $(BIN)
	./$(BIN) +verilator+error+limit+10

clean:
	rm -rf $(OBJDIR)

// ==== test/ttc_timer_tb.sv ====
//----------------------------------------------------------------------------
// ttc timer testbench
// random and directed apb traffic against a cycle model of the timer
// slice, with typed compare tasks on every read and on the irq line
//----------------------------------------------------------------------------
`timescale 1ns/1ps
`include "ttc_params.svh"

module ttc_timer_tb;

  import ttc_reg_pkg::*;
  import ttc_count_pkg::*;

  // random op count and the wait for a full 16-bit wrap
  localparam int NUM_RAND       = 300;
  localparam int OVF_WAIT       = 65540;
  localparam int PLANNED_CYCLES = 10 + 4 * 16 * 3 + NUM_RAND * 7 + 40 * 3 + 70 + OVF_WAIT;
  localparam int CYCLE_LIMIT    = 2 * PLANNED_CYCLES;

  logic                   pclk6;
  logic                   n_p_reset6;
  logic                   psel;
  logic                   penable;
  logic                   pwrite;
  logic [`TTC_ADDR_W-1:0] paddr;
  logic [31:0]            pwdata;
  logic [31:0]            prdata;
  logic                   irq;

  integer      seed;
  int          cycle_cnt;
  logic [31:0] r;
  logic [31:0] data;
  reg_idx_t    idx;

  // model state
  clk_ctrl_t   m_clk;
  cntr_ctrl_t  m_ctrl;
  count_t      m_interval;
  irq_bits_t   m_irq_en;
  irq_bits_t   m_stat;
  irq_bits_t   m_ev;
  count_t      m_count;
  logic [16:0] m_ps;
  logic        m_en;
  logic        m_rs_seen;

  ttc_timer u_ttc_timer (
    .pclk6, .n_p_reset6, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .irq
  );

  always #5 pclk6 = ~pclk6;

  // --------------------------------------------------------------------------
  // failure handling and compare tasks
  // --------------------------------------------------------------------------
  task automatic abort_run();
    $display("Simulation FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_prdata(input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("Fail prdata got %h expected %h", got, exp);
      abort_run();
    end
  endtask

  task automatic check_count(input count_t got, input count_t exp);
    if (got !== exp)
    begin
      $display("Fail count got %h expected %h", got, exp);
      abort_run();
    end
  endtask

  task automatic check_irq_stat(input irq_bits_t got, input irq_bits_t exp);
    if (got !== exp)
    begin
      $display("Fail irq_stat got %h expected %h", got, exp);
      abort_run();
    end
  endtask

  task automatic check_irq(input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("Fail irq got %h expected %h", got, exp);
      abort_run();
    end
  endtask

  // --------------------------------------------------------------------------
  // cycle model
  // --------------------------------------------------------------------------
  task automatic reset_model();
    m_clk      = '0;
    m_ctrl     = '0;
    m_interval = '0;
    m_irq_en   = '0;
    m_stat     = '0;
    m_ev       = '0;
    m_count    = '0;
    m_ps       = '0;
    m_en       = 1'b0;
    m_rs_seen  = 1'b0;
  endtask

  // one clock edge, all next values from the pre-edge state
  task automatic advance_model();
    logic        wr;
    logic        rd;
    reg_idx_t    a;
    logic [16:0] period;
    logic        tick;
    logic        run;
    logic [16:0] nxt_ps;
    count_t      nxt_count;
    irq_bits_t   nxt_ev;
    logic        nxt_en;
    wr        = psel && penable && pwrite && (paddr[7:5] == 3'd0);
    rd        = psel && penable && !pwrite && (paddr[7:5] == 3'd0);
    a         = paddr[4:2];
    // tick every 2^(sel+1) enabled cycles
    period    = 17'd2 << m_clk.psel;
    tick      = !m_clk.ps_en || (m_ps == period - 17'd1);
    run       = m_en && !m_ctrl.dis;
    nxt_ps    = m_ps;
    nxt_count = m_count;
    nxt_ev    = '0;
    if (!m_en || !m_clk.ps_en)
      nxt_ps = '0;
    else if (run)
      nxt_ps = tick ? 17'd0 : m_ps + 17'd1;
    if (!m_en)
      nxt_count = '0;
    else if (run && tick)
    begin
      nxt_ev.match = m_ctrl.interval_mode && (m_count == m_interval);
      nxt_ev.ovf   = !m_ctrl.interval_mode && (m_count == 16'hffff);
      nxt_count    = (nxt_ev.match || nxt_ev.ovf) ? count_t'(0) : m_count + count_t'(1);
    end
    // restart rising edge gives one dead cycle
    if (m_ctrl.restart && !m_rs_seen)
    begin
      m_rs_seen = 1'b1;
      nxt_en    = 1'b0;
    end
    else
    begin
      if (!m_ctrl.restart)
        m_rs_seen = 1'b0;
      nxt_en = 1'b1;
    end
    // pending event survives a clearing read
    if (rd && a == `TTC_REG_IRQ_STAT)
      m_stat = m_ev;
    else
      m_stat = m_stat | m_ev;
    if (wr && a == `TTC_REG_CLK_CTRL)
      m_clk = clk_ctrl_t'(pwdata[6:0]);
    if (wr && a == `TTC_REG_CNTR_CTRL)
      m_ctrl = cntr_ctrl_t'(pwdata[2:0]);
    if (wr && a == `TTC_REG_INTERVAL)
      m_interval = pwdata[`TTC_CNT_W-1:0];
    if (wr && a == `TTC_REG_IRQ_EN)
      m_irq_en = irq_bits_t'(pwdata[1:0]);
    m_ps    = nxt_ps;
    m_count = nxt_count;
    m_ev    = nxt_ev;
    m_en    = nxt_en;
  endtask

  always @(posedge pclk6)
  begin
    if (!n_p_reset6)
      reset_model();
    else
      advance_model();
  end

  function automatic logic [31:0] expected_read(input reg_idx_t a);
    logic [31:0] val;
    val = '0;
    case (a)
      `TTC_REG_CLK_CTRL:  val[6:0] = m_clk;
      `TTC_REG_CNTR_CTRL: val[2:0] = m_ctrl;
      `TTC_REG_INTERVAL:  val[`TTC_CNT_W-1:0] = m_interval;
      `TTC_REG_IRQ_EN:    val[1:0] = m_irq_en;
      `TTC_REG_IRQ_STAT:  val[1:0] = m_stat;
      `TTC_REG_COUNT:     val[`TTC_CNT_W-1:0] = m_count;
      default:            val = '0;
    endcase
    return val;
  endfunction

  // --------------------------------------------------------------------------
  // apb transfers, setup then access then idle
  // --------------------------------------------------------------------------
  task automatic write_reg(input reg_idx_t a, input logic [31:0] wdata);
    @(posedge pclk6);
    #1;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = {3'b000, a, 2'b00};
    pwdata  = wdata;
    @(posedge pclk6);
    #1;
    penable = 1'b1;
    @(posedge pclk6);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  // compare mid access cycle, before the clearing edge
  task automatic read_reg(input reg_idx_t a);
    logic [31:0] exp;
    @(posedge pclk6);
    #1;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = {3'b000, a, 2'b00};
    @(posedge pclk6);
    #1;
    penable = 1'b1;
    @(negedge pclk6);
    exp = expected_read(a);
    case (a)
      `TTC_REG_COUNT:
        check_count(count_t'(prdata[`TTC_CNT_W-1:0]), count_t'(exp[`TTC_CNT_W-1:0]));
      `TTC_REG_IRQ_STAT:
        check_irq_stat(irq_bits_t'(prdata[1:0]), irq_bits_t'(exp[1:0]));
      default:
        check_prdata(prdata, exp);
    endcase
    @(posedge pclk6);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge pclk6);
  endtask

  // irq, assertion flag and timeout, once per cycle
  always @(negedge pclk6)
  begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > CYCLE_LIMIT)
    begin
      $display("timeout, the tests did not finish within %0d cycles", CYCLE_LIMIT);
      abort_run();
    end
    if (n_p_reset6)
    begin
      check_irq(irq, |(m_stat & m_irq_en));
      if (u_ttc_timer.u_assertions.fail_cnt != 0)
      begin
        $display("a bound assertion failed");
        abort_run();
      end
    end
  end

  // --------------------------------------------------------------------------
  // stimulus
  // --------------------------------------------------------------------------
  initial
  begin
    pclk6      = 1'b0;
    n_p_reset6 = 1'b0;
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    paddr      = '0;
    pwdata     = '0;
    cycle_cnt  = 0;
    seed       = 32'h4d9a;
    repeat (10) @(posedge pclk6);
    #1;
    n_p_reset6 = 1'b1;

    // write and read back every offset
    for (int rnd = 0; rnd < 4; rnd++)
    begin
      for (int k = 0; k < 8; k++)
        write_reg(reg_idx_t'(k), $random(seed));
      for (int k = 0; k < 8; k++)
        read_reg(reg_idx_t'(k));
    end

    // random traffic, small prescale and interval
    for (int i = 0; i < NUM_RAND; i++)
    begin
      r   = $random(seed);
      idx = r[4:2];
      if (r[0])
        read_reg(idx);
      else
      begin
        case (idx)
          `TTC_REG_CLK_CTRL:  data = {25'd0, r[10:9], 2'b00, r[6:5], r[7]};
          `TTC_REG_CNTR_CTRL: data = {29'd0, r[8], r[7], r[6] & r[5]};
          `TTC_REG_INTERVAL:  data = {28'd0, r[8:5]};
          default:            data = $random(seed);
        endcase
        write_reg(idx, data);
      end
      wait_cycles(int'(r[12:11]));
    end

    // restart clears once, a held restart does not
    write_reg(`TTC_REG_CLK_CTRL, 32'h0000_0003);
    write_reg(`TTC_REG_CNTR_CTRL, 32'h0);
    wait_cycles(20);
    read_reg(`TTC_REG_COUNT);
    write_reg(`TTC_REG_CNTR_CTRL, 32'h4);
    read_reg(`TTC_REG_COUNT);
    wait_cycles(12);
    write_reg(`TTC_REG_CNTR_CTRL, 32'h4);
    read_reg(`TTC_REG_COUNT);
    // disabled counter holds
    write_reg(`TTC_REG_CNTR_CTRL, 32'h5);
    wait_cycles(10);
    read_reg(`TTC_REG_COUNT);
    read_reg(`TTC_REG_COUNT);

    // interval wrap and match status
    write_reg(`TTC_REG_CLK_CTRL, 32'h0);
    write_reg(`TTC_REG_IRQ_EN, 32'h1);
    write_reg(`TTC_REG_INTERVAL, 32'h6);
    write_reg(`TTC_REG_CNTR_CTRL, 32'h2);
    wait_cycles(16);
    read_reg(`TTC_REG_IRQ_STAT);
    read_reg(`TTC_REG_IRQ_STAT);
    // interval 0 from a restarted count
    // an event every cycle collides with the clearing read
    write_reg(`TTC_REG_INTERVAL, 32'h0);
    write_reg(`TTC_REG_CNTR_CTRL, 32'h6);
    wait_cycles(4);
    read_reg(`TTC_REG_IRQ_STAT);
    read_reg(`TTC_REG_IRQ_STAT);

    // free running overflow from a cleared count
    write_reg(`TTC_REG_IRQ_EN, 32'h2);
    write_reg(`TTC_REG_CNTR_CTRL, 32'h0);
    read_reg(`TTC_REG_IRQ_STAT);
    write_reg(`TTC_REG_CNTR_CTRL, 32'h4);
    wait_cycles(OVF_WAIT);
    read_reg(`TTC_REG_IRQ_STAT);
    read_reg(`TTC_REG_COUNT);
    wait_cycles(2);

    if (u_ttc_timer.u_assertions.fail_cnt != 0)
    begin
      $display("a bound assertion failed during the run");
      abort_run();
    end
    else
    begin
      $display("Simulation PASSED");
      $finish;
    end
  end

endmodule

// ==== test/ttc_timer_assertions.sv ====
//----------------------------------------------------------------------------
// ttc timer assertions
// apb select rule, counter enable pulse width and irq masking
//----------------------------------------------------------------------------
`timescale 1ns/1ps

module ttc_timer_assertions (
  input logic                     pclk6,
  input logic                     n_p_reset6,
  input logic                     psel,
  input logic                     penable,
  input logic                     count_en,
  input ttc_count_pkg::irq_bits_t irq_en,
  input logic                     irq
);

  // failed assertion count, watched by the testbench
  int unsigned fail_cnt = 0;

  // no access phase without select
  a_penable_psel: assert property (@(posedge pclk6) disable iff (!n_p_reset6)
    penable |-> psel)
  else
  begin
    fail_cnt++;
    $error("penable high without psel");
  end

  // enable drop lasts one cycle only
  a_count_en_pulse: assert property (@(posedge pclk6) disable iff (!n_p_reset6)
    !count_en |=> count_en)
  else
  begin
    fail_cnt++;
    $error("count_en low for two cycles in a row");
  end

  // masked line
  a_irq_masked: assert property (@(posedge pclk6) disable iff (!n_p_reset6)
    (irq_en == '0) |-> !irq)
  else
  begin
    fail_cnt++;
    $error("irq high with all interrupts disabled");
  end

endmodule

bind ttc_timer ttc_timer_assertions u_assertions (
  .pclk6      (pclk6),
  .n_p_reset6 (n_p_reset6),
  .psel       (psel),
  .penable    (penable),
  .count_en   (count_en),
  .irq_en     (irq_en),
  .irq        (irq)
);

// ==== design/ttc_timer.sv ====
//----------------------------------------------------------------------------
// ttc timer top level
// single channel timer slice behind an apb register port
//----------------------------------------------------------------------------
`timescale 1ns/1ps
`include "ttc_params.svh"

module ttc_timer (
  input  logic                   pclk6,
  input  logic                   n_p_reset6,
  input  logic                   psel,
  input  logic                   penable,
  input  logic                   pwrite,
  input  logic [`TTC_ADDR_W-1:0] paddr,
  input  logic [31:0]            pwdata,
  output logic [31:0]            prdata,
  output logic                   irq
);

  import ttc_reg_pkg::*;
  import ttc_count_pkg::*;

  // decode to reference block
  logic      clk_ctrl_sel;
  logic      restart;
  // reference block to execute
  logic      count_en;
  clk_ctrl_t clk_ctrl;
  // decode to execute
  logic      cnt_dis;
  logic      interval_mode;
  count_t    interval;
  // execute, result and decode
  count_t    count;
  irq_bits_t events;
  irq_bits_t irq_en;
  irq_bits_t irq_stat;
  logic      stat_rd;

  ttc_reg_decode u_reg_decode (
    .pclk6, .n_p_reset6, .psel, .penable, .pwrite, .paddr, .pwdata,
    .count, .irq_stat, .clk_ctrl, .prdata, .clk_ctrl_sel, .restart,
    .cnt_dis, .interval_mode, .interval, .irq_en, .stat_rd
  );

  ttc_count_rst_lite u_count_rst_lite (
    .pclk6, .n_p_reset6, .pwdata(pwdata[6:0]), .clk_ctrl_sel, .restart,
    .count_en, .clk_ctrl
  );

  ttc_count_exec u_count_exec (
    .pclk6, .n_p_reset6, .count_en, .clk_ctrl, .cnt_dis, .interval_mode,
    .interval, .count, .events
  );

  ttc_irq_result u_irq_result (
    .pclk6, .n_p_reset6, .events, .irq_en, .stat_rd, .irq_stat, .irq
  );

endmodule

// ==== design/ttc_irq_result.sv ====
//----------------------------------------------------------------------------
// ttc interrupt result block
// sticky status bits with clear-on-read and the masked interrupt line
//----------------------------------------------------------------------------
`timescale 1ns/1ps

module ttc_irq_result (
  input  logic                     pclk6,
  input  logic                     n_p_reset6,
  input  ttc_count_pkg::irq_bits_t events,
  input  ttc_count_pkg::irq_bits_t irq_en,
  input  logic                     stat_rd,
  output ttc_count_pkg::irq_bits_t irq_stat,
  output logic                     irq
);

  import ttc_count_pkg::*;

  irq_bits_t stat_q;
  // enabled and pending
  irq_bits_t pend;

  // ------------------------------------------------------------------------
  // status
  // ------------------------------------------------------------------------
  // new event wins over a clearing read
  always_ff @(posedge pclk6 or negedge n_p_reset6)
  begin
    if (!n_p_reset6)
      stat_q <= '0;
    else if (stat_rd)
      stat_q <= events;
    else
      stat_q <= stat_q | events;
  end

  assign irq_stat = stat_q;

  // interrupt line straight from the registered status
  assign pend = stat_q & irq_en;
  assign irq  = |pend;

endmodule

// ==== design/ttc_count_exec.sv ====
//----------------------------------------------------------------------------
// ttc counter execute block
// prescaler and 16-bit up counter, wrapping at the interval value or
// on overflow, with one-cycle event pulses
//----------------------------------------------------------------------------
`timescale 1ns/1ps

module ttc_count_exec (
  input  logic                     pclk6,
  input  logic                     n_p_reset6,
  input  logic                     count_en,
  input  ttc_reg_pkg::clk_ctrl_t   clk_ctrl,
  input  logic                     cnt_dis,
  input  logic                     interval_mode,
  input  ttc_count_pkg::count_t    interval,
  output ttc_count_pkg::count_t    count,
  output ttc_count_pkg::irq_bits_t events
);

  import ttc_count_pkg::*;

  psel_t       ps_sel;
  logic        ps_en;
  logic [15:0] ps_term;
  logic [15:0] ps_cnt;
  logic        tick;
  logic        run;
  logic        step;
  logic        hit_match;
  logic        hit_ovf;
  count_t      count_q;
  irq_bits_t   events_q;

  // ------------------------------------------------------------------------
  // prescaler
  // ------------------------------------------------------------------------
  assign ps_sel = clk_ctrl.psel;
  assign ps_en  = clk_ctrl.ps_en;

  // terminal count 2^(sel+1)-1
  assign ps_term = 16'hffff >> (4'd15 - ps_sel);

  // counting allowed this cycle
  assign run = count_en & ~cnt_dis;

  // every cycle when prescale is off
  assign tick = ~ps_en | (ps_cnt == ps_term);

  always_ff @(posedge pclk6 or negedge n_p_reset6)
  begin
    if (!n_p_reset6)
      ps_cnt <= '0;
    else if (!count_en || !ps_en)
      ps_cnt <= '0;
    else if (run)
    begin
      if (tick)
        ps_cnt <= '0;
      else
        ps_cnt <= ps_cnt + 16'd1;
    end
  end

  // ------------------------------------------------------------------------
  // main counter
  // ------------------------------------------------------------------------
  assign step = run & tick;

  // wrap conditions, one per mode
  assign hit_match = interval_mode & (count_q == interval);
  assign hit_ovf   = ~interval_mode & (count_q == '1);

  always_ff @(posedge pclk6 or negedge n_p_reset6)
  begin
    if (!n_p_reset6)
    begin
      count_q  <= '0;
      events_q <= '0;
    end
    else
    begin
      // pulses last one cycle
      events_q <= '0;
      if (!count_en)
        count_q <= '0;
      else if (step)
      begin
        if (hit_match || hit_ovf)
          count_q <= '0;
        else
          count_q <= count_q + 1'b1;
        events_q.match <= hit_match;
        events_q.ovf   <= hit_ovf;
      end
    end
  end

  assign count  = count_q;
  assign events = events_q;

endmodule

// ==== design/ttc_count_rst_lite.sv ====
//----------------------------------------------------------------------------
// ttc counter reset block
// holds the clock control word and drops the counter enable for one
// cycle on each rising edge of restart
//----------------------------------------------------------------------------
`timescale 1ns/1ps

module ttc_count_rst_lite (
  input  logic                   pclk6,
  input  logic                   n_p_reset6,
  input  logic [6:0]             pwdata,
  input  logic                   clk_ctrl_sel,
  input  logic                   restart,
  output logic                   count_en,
  output ttc_reg_pkg::clk_ctrl_t clk_ctrl
);

  import ttc_reg_pkg::*;

  clk_ctrl_t clk_ctrl_q;
  // remembered restart level
  logic      restart_seen;
  logic      count_en_q;

  // ------------------------------------------------------------------------
  // restart edge and counter enable
  // ------------------------------------------------------------------------
  // 0 out of reset, 1 from the first clock on
  always_ff @(posedge pclk6 or negedge n_p_reset6)
  begin
    if (!n_p_reset6)
    begin
      restart_seen <= 1'b0;
      count_en_q   <= 1'b0;
    end
    else if (restart && !restart_seen)
    begin
      // new restart, one dead cycle
      restart_seen <= 1'b1;
      count_en_q   <= 1'b0;
    end
    else
    begin
      // held restart stays armed until software clears it
      if (!restart)
        restart_seen <= 1'b0;
      count_en_q <= 1'b1;
    end
  end

  // ------------------------------------------------------------------------
  // clock control register
  // ------------------------------------------------------------------------
  always_ff @(posedge pclk6 or negedge n_p_reset6)
  begin
    if (!n_p_reset6)
      clk_ctrl_q <= '0;
    else if (clk_ctrl_sel)
      clk_ctrl_q <= clk_ctrl_t'(pwdata);
  end

  assign count_en = count_en_q;
  assign clk_ctrl = clk_ctrl_q;

endmodule

// ==== design/ttc_reg_decode.sv ====
//----------------------------------------------------------------------------
// ttc register decode
// apb access decode, counter control, interval and interrupt enable
// registers, and the read data mux
//----------------------------------------------------------------------------
`timescale 1ns/1ps
`include "ttc_params.svh"

module ttc_reg_decode (
  input  logic                          pclk6,
  input  logic                          n_p_reset6,
  input  logic                          psel,
  input  logic                          penable,
  input  logic                          pwrite,
  input  logic [`TTC_ADDR_W-1:0]        paddr,
  input  logic [31:0]                   pwdata,
  input  ttc_count_pkg::count_t         count,
  input  ttc_count_pkg::irq_bits_t      irq_stat,
  input  ttc_reg_pkg::clk_ctrl_t        clk_ctrl,
  output logic [31:0]                   prdata,
  output logic                          clk_ctrl_sel,
  output logic                          restart,
  output logic                          cnt_dis,
  output logic                          interval_mode,
  output ttc_count_pkg::count_t         interval,
  output ttc_count_pkg::irq_bits_t      irq_en,
  output logic                          stat_rd
);

  import ttc_reg_pkg::*;
  import ttc_count_pkg::*;

  reg_idx_t   idx;
  logic       addr_hit;
  logic       wr_acc;
  logic       rd_acc;
  cntr_ctrl_t cntr_ctrl_q;
  count_t     interval_q;
  irq_bits_t  irq_en_q;

  // ------------------------------------------------------------------------
  // access decode
  // ------------------------------------------------------------------------
  // word index, upper address bits must be clear
  assign idx      = paddr[4:2];
  assign addr_hit = (paddr[`TTC_ADDR_W-1:5] == '0);

  // access phase only
  assign wr_acc = psel & penable & pwrite & addr_hit;
  assign rd_acc = psel & penable & ~pwrite & addr_hit;

  // clock control lives in the reference block
  assign clk_ctrl_sel = wr_acc & (idx == `TTC_REG_CLK_CTRL);

  // status read pulse for clear-on-read
  assign stat_rd = rd_acc & (idx == `TTC_REG_IRQ_STAT);

  // ------------------------------------------------------------------------
  // local registers
  // ------------------------------------------------------------------------
  always_ff @(posedge pclk6 or negedge n_p_reset6)
  begin
    if (!n_p_reset6)
    begin
      cntr_ctrl_q <= '0;
      interval_q  <= '0;
      irq_en_q    <= '0;
    end
    else
    begin
      if (wr_acc && idx == `TTC_REG_CNTR_CTRL)
        cntr_ctrl_q <= cntr_ctrl_t'(pwdata[2:0]);
      if (wr_acc && idx == `TTC_REG_INTERVAL)
        interval_q <= pwdata[`TTC_CNT_W-1:0];
      if (wr_acc && idx == `TTC_REG_IRQ_EN)
        irq_en_q <= irq_bits_t'(pwdata[1:0]);
    end
  end

  // restart is a level, edge handling downstream
  assign restart       = cntr_ctrl_q.restart;
  assign cnt_dis       = cntr_ctrl_q.dis;
  assign interval_mode = cntr_ctrl_q.interval_mode;
  assign interval      = interval_q;
  assign irq_en        = irq_en_q;

  // read mux, zero extended
  // unused offsets and out of range addresses read 0
  always_comb
  begin
    prdata = '0;
    if (addr_hit)
    begin
      case (idx)
        `TTC_REG_CLK_CTRL:  prdata[6:0] = clk_ctrl;
        `TTC_REG_CNTR_CTRL: prdata[2:0] = cntr_ctrl_q;
        `TTC_REG_INTERVAL:  prdata[`TTC_CNT_W-1:0] = interval_q;
        `TTC_REG_IRQ_EN:    prdata[1:0] = irq_en_q;
        `TTC_REG_IRQ_STAT:  prdata[1:0] = irq_stat;
        `TTC_REG_COUNT:     prdata[`TTC_CNT_W-1:0] = count;
        default:            prdata = '0;
      endcase
    end
  end

endmodule

// ==== design/ttc_count_pkg.sv ====
//----------------------------------------------------------------------------
// ttc counting types
// count value, prescale select and interrupt bit layout
//----------------------------------------------------------------------------
`include "ttc_params.svh"

package ttc_count_pkg;

  // counter and interval value
  typedef logic [`TTC_CNT_W-1:0] count_t;

  // prescale select, period is 2^(sel+1)
  typedef logic [3:0] psel_t;

  // interrupt bits
  // bit 0 interval match, bit 1 overflow
  typedef struct packed {
    logic ovf;
    logic match;
  } irq_bits_t;

endpackage

// ==== design/ttc_reg_pkg.sv ====
//----------------------------------------------------------------------------
// ttc register types
// register index and the field layout of the control words
//----------------------------------------------------------------------------
package ttc_reg_pkg;

  // decoded word index from paddr[4:2]
  typedef logic [2:0] reg_idx_t;

  // clock control word, 7 bits
  // bit 0 prescale enable
  // bits 4:1 prescale select
  // bits 6:5 spare, stored and read back only
  typedef struct packed {
    logic [1:0] spare;
    logic [3:0] psel;
    logic       ps_en;
  } clk_ctrl_t;

  // counter control word, 3 bits
  // bit 0 disable, bit 1 interval mode, bit 2 restart
  typedef struct packed {
    logic restart;
    logic interval_mode;
    logic dis;
  } cntr_ctrl_t;

endpackage

// ==== design/ttc_params.svh ====
//----------------------------------------------------------------------------
// ttc timer parameters
// data path widths and the register word offsets of the timer slice
//----------------------------------------------------------------------------
`ifndef TTC_PARAMS_SVH
`define TTC_PARAMS_SVH

// counter and interval width
`define TTC_CNT_W 16

// apb address width
`define TTC_ADDR_W 8

// word offsets, matched against paddr bits 4:2
`define TTC_REG_CLK_CTRL  3'd0
`define TTC_REG_CNTR_CTRL 3'd1
`define TTC_REG_INTERVAL  3'd2
`define TTC_REG_IRQ_EN    3'd3
`define TTC_REG_IRQ_STAT  3'd4
`define TTC_REG_COUNT     3'd5

`endif
